//--- hw/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data path width of the integer core
`define XLEN 32

// register file address width
`define REG_AW 5

// one quotient bit per divider iteration
`define DIV_CYCLES `XLEN

`endif

//--- hw/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_op_t;

  typedef enum logic [2:0] {
    LSU_LB  = 3'd0,
    LSU_LBU = 3'd1,
    LSU_LH  = 3'd2,
    LSU_LHU = 3'd3,
    LSU_LW  = 3'd4
  } lsu_op_t;

  typedef struct packed {
    logic valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] address; // effective address, or pc + imm for auipc
    logic [`REG_AW-1:0] waddr;
    logic wren;
    logic rden2;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic load;
    logic store;
    logic division;
    logic nop;
    alu_op_t alu_op;
    div_op_t div_op;
    lsu_op_t lsu_op;
    logic [3:0] byteenable;
  } dec_in_t;

  typedef struct packed {
    dec_in_t d;
    logic stall;
    logic clear;
  } exec_reg_t;

  localparam exec_reg_t init_exec_reg = exec_reg_t'('0);

  typedef struct packed {
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] imm;
    logic sel; // high picks rdata2 as the second operand
    alu_op_t alu_op;
  } alu_in_t;

  typedef struct packed {
    logic [`XLEN-1:0] result;
  } alu_out_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic enable;
    div_op_t op;
  } div_in_t;

  typedef struct packed {
    logic ready;
    logic [`XLEN-1:0] result;
  } div_out_t;

  typedef struct packed {
    logic [`XLEN-1:0] ldata;
    logic [3:0] byteenable;
    lsu_op_t lsu_op;
  } lsu_in_t;

  typedef struct packed {
    logic [`XLEN-1:0] result;
  } lsu_out_t;

  typedef struct packed {
    logic mem_ready;
    logic [`XLEN-1:0] mem_rdata;
  } mem_out_t;

  typedef struct packed {
    logic wren;
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0] wdata;
  } reg_write_t;

endpackage

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "exec_consts.svh"

module execute_stage (
  input logic clock,
  input logic reset,
  input exec_pkg::dec_in_t dec_in,
  input logic flush,
  input exec_pkg::mem_out_t dmem_out,
  output logic stall,
  output exec_pkg::reg_write_t reg_write,
  output exec_pkg::alu_in_t alu_in,
  input exec_pkg::alu_out_t alu_out,
  output exec_pkg::div_in_t div_in,
  input exec_pkg::div_out_t div_out,
  output exec_pkg::lsu_in_t lsu_in,
  input exec_pkg::lsu_out_t lsu_out
);
  import exec_pkg::*;

  exec_reg_t r;
  exec_reg_t rin;
  exec_reg_t v;

  logic wren;
  logic [`XLEN-1:0] wdata;
  logic div_op;
  logic mem_op;

  always_comb begin
    v = r;

    // a stalled instruction stays put and the decode side is ignored
    if (r.stall == 0) begin
      v.d = dec_in;
    end

    v.stall = 0;
    v.clear = flush;

    if (v.d.nop == 1) begin
      v.d.valid = 0;
    end

    alu_in.rdata1 = v.d.rdata1;
    alu_in.rdata2 = v.d.rdata2;
    alu_in.imm = v.d.imm;
    alu_in.sel = v.d.rden2;
    alu_in.alu_op = v.d.alu_op;

    wren = v.d.valid & v.d.wren;
    wdata = alu_out.result;

    if (v.d.auipc == 1) begin
      wdata = v.d.address;
    end else if (v.d.lui == 1) begin
      wdata = v.d.imm;
    end else if (v.d.jal == 1 || v.d.jalr == 1) begin
      wdata = v.d.npc; // link address
    end

    div_op = v.d.valid & v.d.division;
    mem_op = v.d.valid & (v.d.load | v.d.store);

    div_in.rdata1 = v.d.rdata1;
    div_in.rdata2 = v.d.rdata2;
    div_in.enable = div_op & ~(v.clear | r.stall); // only on the first cycle in the stage
    div_in.op = v.d.div_op;

    lsu_in.ldata = dmem_out.mem_rdata;
    lsu_in.byteenable = v.d.byteenable;
    lsu_in.lsu_op = v.d.lsu_op;

    if (div_op == 1) begin
      if (div_out.ready == 0 || r.stall == 0) begin
        v.stall = 1; // a ready in the first cycle belongs to a flushed divide
      end else begin
        wren = 1;
        wdata = div_out.result;
      end
    end

    if (mem_op == 1) begin
      if (dmem_out.mem_ready == 0) begin
        v.stall = 1;
      end else begin
        wren = v.d.load; // a store finishes without a write
        wdata = lsu_out.result;
      end
    end

    if ((v.stall | v.clear) == 1) begin
      wren = 0;
    end

    if (v.clear == 1) begin
      v.stall = 0; // flush releases the pipeline at once
    end

    stall = v.stall;

    reg_write.wren = wren & |v.d.waddr; // x0 is never written
    reg_write.waddr = v.d.waddr;
    reg_write.wdata = wdata;

    rin = v;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r <= init_exec_reg;
    end else begin
      r <= rin;
    end
  end

  // after a stall cycle a write needs the pending unit to have finished
  assert property (@(posedge clock) disable iff (reset == 0)
    stall |=> !reg_write.wren || div_out.ready || dmem_out.mem_ready)
    else $error("register write raised before the stalled operation finished");

  assert property (@(posedge clock) disable iff (reset == 0)
    dec_in.valid |-> !(dec_in.load && dec_in.division))
    else $error("decoded instruction is both a load and a divide");

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

module execute_unit (
  input logic clock,
  input logic reset,
  input exec_pkg::dec_in_t dec_in,
  input logic flush,
  input exec_pkg::mem_out_t dmem_out,
  output exec_pkg::reg_write_t reg_write,
  output logic stall
);
  import exec_pkg::*;

  alu_in_t alu_in;
  alu_out_t alu_out;
  div_in_t div_in;
  div_out_t div_out;
  lsu_in_t lsu_in;
  lsu_out_t lsu_out;

  execute_stage u_stage (
    .clock     (clock),
    .reset     (reset),
    .dec_in    (dec_in),
    .flush     (flush),
    .dmem_out  (dmem_out),
    .stall     (stall),
    .reg_write (reg_write),
    .alu_in    (alu_in),
    .alu_out   (alu_out),
    .div_in    (div_in),
    .div_out   (div_out),
    .lsu_in    (lsu_in),
    .lsu_out   (lsu_out)
  );

  int_alu u_alu (
    .alu_in  (alu_in),
    .alu_out (alu_out)
  );

  iter_divider u_div (
    .clock   (clock),
    .reset   (reset),
    .div_in  (div_in),
    .div_out (div_out)
  );

  load_align u_lsu (
    .lsu_in  (lsu_in),
    .lsu_out (lsu_out)
  );

endmodule

`default_nettype wire

//--- hw/int_alu.sv
`default_nettype none
`timescale 1ns/100ps

`include "exec_consts.svh"

module int_alu (
  input exec_pkg::alu_in_t alu_in,
  output exec_pkg::alu_out_t alu_out
);
  import exec_pkg::*;

  localparam int SW = $clog2(`XLEN);

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [SW-1:0] shamt;
  logic [`XLEN-1:0] res;

  always_comb begin
    op1 = alu_in.rdata1;
    op2 = alu_in.sel ? alu_in.rdata2 : alu_in.imm; // register form or immediate form
    shamt = op2[SW-1:0];

    case (alu_in.alu_op)
      ALU_ADD: begin
        res = op1 + op2;
      end
      ALU_SUB: begin
        res = op1 - op2;
      end
      ALU_SLL: begin
        res = op1 << shamt;
      end
      ALU_SLT: begin
        res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      end
      ALU_SLTU: begin
        res = {{(`XLEN-1){1'b0}}, op1 < op2};
      end
      ALU_XOR: begin
        res = op1 ^ op2;
      end
      ALU_SRL: begin
        res = op1 >> shamt;
      end
      ALU_SRA: begin
        res = $signed(op1) >>> shamt; // sign bit fills from the left
      end
      ALU_OR: begin
        res = op1 | op2;
      end
      ALU_AND: begin
        res = op1 & op2;
      end
      default: begin
        res = '0;
      end
    endcase

    alu_out.result = res;
  end

endmodule

`default_nettype wire

//--- hw/iter_divider.sv
`default_nettype none
`timescale 1ns/100ps

`include "exec_consts.svh"

module iter_divider (
  input logic clock,
  input logic reset,
  input exec_pkg::div_in_t div_in,
  output exec_pkg::div_out_t div_out
);
  import exec_pkg::*;

  localparam int CW = $clog2(`DIV_CYCLES + 1);

  logic [CW-1:0] count;
  logic busy;
  logic ready;

  logic [`XLEN-1:0] rem;
  logic [`XLEN-1:0] quo;
  logic [`XLEN-1:0] divisor;
  logic [`XLEN-1:0] dividend;
  div_op_t op;
  logic neg_quo;
  logic neg_rem;
  logic by_zero;
  logic overflow;

  logic is_signed;
  logic [`XLEN-1:0] abs_a;
  logic [`XLEN-1:0] abs_b;
  logic [`XLEN:0] shifted;
  logic [`XLEN:0] diff;
  logic [`XLEN-1:0] quo_fix;
  logic [`XLEN-1:0] rem_fix;

  always_comb begin
    is_signed = (div_in.op == DIV_DIV) || (div_in.op == DIV_REM);
    abs_a = (is_signed && div_in.rdata1[`XLEN-1]) ? -div_in.rdata1 : div_in.rdata1;
    abs_b = (is_signed && div_in.rdata2[`XLEN-1]) ? -div_in.rdata2 : div_in.rdata2;
    shifted = {rem, quo[`XLEN-1]}; // bring down the next dividend bit
    diff = shifted - {1'b0, divisor};
  end

  // a new enable restarts the divider, so a flushed divide is simply dropped
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy <= 0;
      ready <= 0;
      count <= '0;
    end else begin
      ready <= 0;
      if (div_in.enable) begin
        busy <= 1;
        count <= CW'(`DIV_CYCLES);
      end else if (busy) begin
        count <= count - CW'(1);
        if (count == CW'(1)) begin
          busy <= 0;
          ready <= 1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (div_in.enable) begin
      rem <= '0;
      quo <= abs_a; // quotient bits shift in as the dividend shifts out
      divisor <= abs_b;
      dividend <= div_in.rdata1;
      op <= div_in.op;
      by_zero <= (div_in.rdata2 == '0);
      overflow <= is_signed && (div_in.rdata1 == {1'b1, {(`XLEN-1){1'b0}}})
                  && (&div_in.rdata2);
      neg_quo <= is_signed && (div_in.rdata1[`XLEN-1] ^ div_in.rdata2[`XLEN-1]);
      neg_rem <= is_signed && div_in.rdata1[`XLEN-1];
    end else if (busy) begin
      if (diff[`XLEN] == 0) begin
        rem <= diff[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b1};
      end else begin
        rem <= shifted[`XLEN-1:0]; // restore when the divisor did not fit
        quo <= {quo[`XLEN-2:0], 1'b0};
      end
    end
  end

  always_comb begin
    quo_fix = neg_quo ? -quo : quo;
    rem_fix = neg_rem ? -rem : rem; // remainder takes the dividend sign
    if (by_zero) begin
      quo_fix = '1;
      rem_fix = dividend;
    end else if (overflow) begin
      quo_fix = dividend;
      rem_fix = '0;
    end
    div_out.ready = ready;
    div_out.result = (op == DIV_DIV || op == DIV_DIVU) ? quo_fix : rem_fix;
  end

  assert property (@(posedge clock) disable iff (reset == 0)
    div_out.ready |=> !div_out.ready)
    else $error("divider ready held for more than one cycle");

endmodule

`default_nettype wire

//--- hw/load_align.sv
`default_nettype none
`timescale 1ns/100ps

`include "exec_consts.svh"

module load_align (
  input exec_pkg::lsu_in_t lsu_in,
  output exec_pkg::lsu_out_t lsu_out
);
  import exec_pkg::*;

  logic [7:0] byte_lane;
  logic [15:0] half_lane;

  always_comb begin
    case (lsu_in.byteenable)
      4'b0010: byte_lane = lsu_in.ldata[15:8];
      4'b0100: byte_lane = lsu_in.ldata[23:16];
      4'b1000: byte_lane = lsu_in.ldata[31:24];
      default: byte_lane = lsu_in.ldata[7:0];
    endcase

    half_lane = lsu_in.byteenable[2] ? lsu_in.ldata[31:16] : lsu_in.ldata[15:0]; // upper half when enabled

    case (lsu_in.lsu_op)
      LSU_LB: begin
        lsu_out.result = {{(`XLEN-8){byte_lane[7]}}, byte_lane};
      end
      LSU_LBU: begin
        lsu_out.result = {{(`XLEN-8){1'b0}}, byte_lane};
      end
      LSU_LH: begin
        lsu_out.result = {{(`XLEN-16){half_lane[15]}}, half_lane};
      end
      LSU_LHU: begin
        lsu_out.result = {{(`XLEN-16){1'b0}}, half_lane};
      end
      default: begin
        lsu_out.result = lsu_in.ldata; // word load, no extension
      end
    endcase
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the execute unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_execute_unit -o tb_execute_unit
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_execute_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
+incdir+hw
hw/exec_pkg.sv
hw/int_alu.sv
hw/iter_divider.sv
hw/load_align.sv
hw/execute_stage.sv
hw/execute_unit.sv
sim/tb_execute_unit.sv

//--- sim/tb_execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "exec_consts.svh"

module tb_execute_unit;
  import exec_pkg::*;

  localparam int PERIOD = 100;
  localparam int FLUSH_AT = 3; // cycle of a flushed row in which flush goes high

  typedef struct packed {
    dec_in_t instr;
    int lat; // cycles before mem_ready where -1 draws a random latency
    logic [`XLEN-1:0] mdata;
    logic flush;
    logic exp_wren;
    logic [`REG_AW-1:0] exp_waddr;
    logic [`XLEN-1:0] exp_wdata;
  } row_t;

  logic clock;
  logic reset;
  dec_in_t dec_in;
  logic flush;
  mem_out_t dmem_out;
  reg_write_t reg_write;
  logic stall;

  row_t rows[$];
  int errors;
  integer seed;

  execute_unit DUT (
    .clock     (clock),
    .reset     (reset),
    .dec_in    (dec_in),
    .flush     (flush),
    .dmem_out  (dmem_out),
    .reg_write (reg_write),
    .stall     (stall)
  );

  initial begin
    clock = 0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL at %0t: %s expected %h, actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic dec_in_t base_instr(input logic [4:0] rd, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] imm);
    dec_in_t d;
    d = '0;
    d.valid = 1'b1;
    d.pc = 32'h100;
    d.npc = 32'h104;
    d.waddr = rd;
    d.wren = 1'b1;
    d.rdata1 = a;
    d.rdata2 = b;
    d.imm = imm;
    return d;
  endfunction

  // rr picks the register form, otherwise b is the immediate
  function automatic dec_in_t alu_instr(input alu_op_t op, input logic [4:0] rd,
                                        input logic [31:0] a, input logic [31:0] b, input bit rr);
    dec_in_t d;
    d = rr ? base_instr(rd, a, b, 32'h0) : base_instr(rd, a, 32'h0, b);
    d.rden2 = rr;
    d.alu_op = op;
    return d;
  endfunction

  // kind 0 is lui, 1 auipc, 2 jal, 3 jalr
  function automatic dec_in_t upper_instr(input int kind, input logic [4:0] rd,
                                          input logic [31:0] pc, input logic [31:0] imm);
    dec_in_t d;
    d = base_instr(rd, 32'h0, 32'h0, imm);
    d.pc = pc;
    d.npc = pc + 32'd4;
    d.address = pc + imm; // decode computes pc + imm for auipc
    case (kind)
      0: d.lui = 1'b1;
      1: d.auipc = 1'b1;
      2: d.jal = 1'b1;
      default: d.jalr = 1'b1;
    endcase
    return d;
  endfunction

  function automatic dec_in_t div_instr(input div_op_t op, input logic [4:0] rd,
                                        input logic [31:0] a, input logic [31:0] b);
    dec_in_t d;
    d = base_instr(rd, a, b, 32'h0);
    d.division = 1'b1;
    d.div_op = op;
    return d;
  endfunction

  function automatic dec_in_t load_instr(input lsu_op_t op, input logic [4:0] rd,
                                         input logic [3:0] be);
    dec_in_t d;
    d = base_instr(rd, 32'h1000, 32'h0, 32'h0);
    d.load = 1'b1;
    d.lsu_op = op;
    d.byteenable = be;
    d.address = 32'h1000;
    return d;
  endfunction

  // a nonzero waddr leaves only the store rule to keep wren low
  function automatic dec_in_t store_instr(input logic [3:0] be);
    dec_in_t d;
    d = base_instr(5'd9, 32'h1000, 32'h5a5a_5a5a, 32'h0);
    d.wren = 1'b0;
    d.store = 1'b1;
    d.byteenable = be;
    d.address = 32'h1000;
    return d;
  endfunction

  task automatic add_row(input dec_in_t d, input int lat, input logic [31:0] mdata,
                         input logic fl, input logic ew, input logic [31:0] wd);
    row_t r;
    r.instr = d;
    r.lat = lat;
    r.mdata = mdata;
    r.flush = fl;
    r.exp_wren = ew;
    r.exp_waddr = d.waddr;
    r.exp_wdata = wd;
    rows.push_back(r);
  endtask

  task automatic fill_table();
    add_row(alu_instr(ALU_ADD, 5'd1, 32'd7, 32'd9, 1'b1), 0, '0, 1'b0, 1'b1, 32'h0000_0010);
    add_row(alu_instr(ALU_SUB, 5'd2, 32'd5, 32'd8, 1'b1), 0, '0, 1'b0, 1'b1, 32'hffff_fffd);
    add_row(alu_instr(ALU_SLL, 5'd3, 32'd3, 32'h24, 1'b0), 0, '0, 1'b0, 1'b1, 32'h0000_0030);
    add_row(alu_instr(ALU_SLT, 5'd4, '1, 32'd1, 1'b1), 0, '0, 1'b0, 1'b1, 32'h0000_0001);
    add_row(alu_instr(ALU_SLTU, 5'd5, '1, 32'd1, 1'b0), 0, '0, 1'b0, 1'b1, 32'h0000_0000);
    add_row(alu_instr(ALU_XOR, 5'd6, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 1'b1), 0, '0, 1'b0, 1'b1,
            32'hff00_ff00);
    add_row(alu_instr(ALU_SRL, 5'd7, 32'h8000_0000, 32'd4, 1'b1), 0, '0, 1'b0, 1'b1,
            32'h0800_0000);
    add_row(alu_instr(ALU_SRA, 5'd8, 32'h8000_0000, 32'd4, 1'b0), 0, '0, 1'b0, 1'b1,
            32'hf800_0000);
    add_row(alu_instr(ALU_OR, 5'd9, 32'h1234_0000, 32'h5678, 1'b0), 0, '0, 1'b0, 1'b1,
            32'h1234_5678);
    add_row(alu_instr(ALU_AND, 5'd10, 32'hffff_00ff, 32'h0f0f_0f0f, 1'b1), 0, '0, 1'b0, 1'b1,
            32'h0f0f_000f);
    add_row(upper_instr(0, 5'd11, 32'h100, 32'habcd_e000), 0, '0, 1'b0, 1'b1, 32'habcd_e000);
    add_row(upper_instr(1, 5'd12, 32'h100, 32'h1234_5000), 0, '0, 1'b0, 1'b1, 32'h1234_5100);
    add_row(upper_instr(2, 5'd1, 32'h200, 32'h40), 0, '0, 1'b0, 1'b1, 32'h0000_0204);
    add_row(upper_instr(3, 5'd13, 32'h300, 32'h0), 0, '0, 1'b0, 1'b1, 32'h0000_0304);
    add_row(alu_instr(ALU_ADD, 5'd0, 32'd1, 32'd2, 1'b1), 0, '0, 1'b0, 1'b0, 32'h0);
    add_row(div_instr(DIV_DIV, 5'd14, 32'hffff_ffec, 32'd3), 0, '0, 1'b0, 1'b1, 32'hffff_fffa);
    add_row(div_instr(DIV_REM, 5'd15, 32'hffff_ffec, 32'd3), 0, '0, 1'b0, 1'b1, 32'hffff_fffe);
    add_row(div_instr(DIV_DIVU, 5'd16, 32'hffff_ffec, 32'd3), 0, '0, 1'b0, 1'b1, 32'h5555_554e);
    add_row(div_instr(DIV_REMU, 5'd17, 32'hffff_ffec, 32'd3), 0, '0, 1'b0, 1'b1, 32'h0000_0002);
    add_row(div_instr(DIV_DIV, 5'd18, 32'd7, 32'hffff_fffe), 0, '0, 1'b0, 1'b1, 32'hffff_fffd);
    add_row(div_instr(DIV_REM, 5'd19, 32'd7, 32'hffff_fffe), 0, '0, 1'b0, 1'b1, 32'h0000_0001);
    add_row(div_instr(DIV_DIV, 5'd20, 32'd100, 32'd0), 0, '0, 1'b0, 1'b1, 32'hffff_ffff);
    add_row(div_instr(DIV_DIVU, 5'd21, 32'd100, 32'd0), 0, '0, 1'b0, 1'b1, 32'hffff_ffff);
    add_row(div_instr(DIV_REM, 5'd22, 32'hffff_fff9, 32'd0), 0, '0, 1'b0, 1'b1, 32'hffff_fff9);
    add_row(div_instr(DIV_REMU, 5'd23, 32'd100, 32'd0), 0, '0, 1'b0, 1'b1, 32'h0000_0064);
    add_row(div_instr(DIV_DIV, 5'd24, 32'h8000_0000, '1), 0, '0, 1'b0, 1'b1, 32'h8000_0000);
    add_row(div_instr(DIV_REM, 5'd25, 32'h8000_0000, '1), 0, '0, 1'b0, 1'b1, 32'h0000_0000);
    add_row(div_instr(DIV_DIV, 5'd0, 32'd50, 32'd7), 0, '0, 1'b0, 1'b0, 32'h0);
    add_row(div_instr(DIV_DIV, 5'd26, 32'd50, 32'd7), 0, '0, 1'b1, 1'b0, 32'h0);
    add_row(div_instr(DIV_DIV, 5'd26, 32'd50, 32'd7), 0, '0, 1'b0, 1'b1, 32'h0000_0007);
    add_row(load_instr(LSU_LB, 5'd27, 4'b0001), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_0054);
    add_row(load_instr(LSU_LB, 5'd28, 4'b0010), -1, 32'h8172_e354, 1'b0, 1'b1, 32'hffff_ffe3);
    add_row(load_instr(LSU_LB, 5'd29, 4'b0100), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_0072);
    add_row(load_instr(LSU_LB, 5'd30, 4'b1000), -1, 32'h8172_e354, 1'b0, 1'b1, 32'hffff_ff81);
    add_row(load_instr(LSU_LBU, 5'd31, 4'b1000), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_0081);
    add_row(load_instr(LSU_LBU, 5'd1, 4'b0010), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_00e3);
    add_row(load_instr(LSU_LBU, 5'd2, 4'b0001), 0, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_0054);
    add_row(load_instr(LSU_LH, 5'd3, 4'b0011), -1, 32'h8172_e354, 1'b0, 1'b1, 32'hffff_e354);
    add_row(load_instr(LSU_LH, 5'd4, 4'b1100), -1, 32'h7ffe_0000, 1'b0, 1'b1, 32'h0000_7ffe);
    add_row(load_instr(LSU_LHU, 5'd5, 4'b1100), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_8172);
    add_row(load_instr(LSU_LHU, 5'd6, 4'b0011), -1, 32'h8172_e354, 1'b0, 1'b1, 32'h0000_e354);
    add_row(load_instr(LSU_LW, 5'd7, 4'b1111), -1, 32'hdead_beef, 1'b0, 1'b1, 32'hdead_beef);
    add_row(store_instr(4'b1111), -1, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(load_instr(LSU_LW, 5'd0, 4'b1111), 2, 32'h1234_5678, 1'b0, 1'b0, 32'h0);
  endtask

  task automatic run_row(input row_t r);
    int lat;
    int want;
    int k;
    logic is_mem;
    logic done;
    lat = r.lat;
    if (lat < 0) begin
      lat = $unsigned($random(seed)) % 6;
    end
    is_mem = r.instr.load | r.instr.store;
    if (r.flush) begin
      want = FLUSH_AT;
    end else if (r.instr.division) begin
      want = `DIV_CYCLES + 1;
    end else if (is_mem) begin
      want = lat;
    end else begin
      want = 0;
    end
    k = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      #10;
      dec_in = r.instr; // held stable while the stage stalls
      flush = r.flush & (k == FLUSH_AT);
      dmem_out.mem_ready = is_mem & (k == lat);
      dmem_out.mem_rdata = dmem_out.mem_ready ? r.mdata : '0;
      @(negedge clock);
      if (stall) begin
        check_value("reg_write.wren during stall", 32'h0, 32'(reg_write.wren));
        k++;
        if (k > `DIV_CYCLES + 10) begin
          $display("stall never dropped for the instruction that writes x%0d", r.instr.waddr);
          errors++;
          done = 1'b1;
        end
      end else begin
        check_value("stall cycles", want, k);
        check_value("reg_write.wren", 32'(r.exp_wren), 32'(reg_write.wren));
        if (r.exp_wren) begin
          check_value("reg_write.waddr", 32'(r.exp_waddr), 32'(reg_write.waddr));
          check_value("reg_write.wdata", r.exp_wdata, reg_write.wdata);
        end
        done = 1'b1;
      end
    end
  endtask

  initial begin
    errors = 0;
    seed = 32'hdfcb;
    reset = 1'b0;
    flush = 1'b0;
    dec_in = '0;
    dmem_out = '0;
    fill_table();
    repeat (4) @(posedge clock);
    #10;
    reset = 1'b1;
    @(negedge clock);
    check_value("stall after reset", 32'h0, 32'(stall));
    check_value("reg_write.wren after reset", 32'h0, 32'(reg_write.wren));
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    @(posedge clock);
    #10;
    dec_in = '0;
    flush = 1'b0;
    dmem_out = '0;
    $display("%0d rows applied, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // every row gets room for a full divide plus some slack
  initial begin
    int limit;
    #1;
    limit = rows.size() * (`DIV_CYCLES + 20) + 10;
    repeat (limit) @(posedge clock);
    $display("watchdog timeout after %0d clock cycles, the table did not finish", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
